// File: afu_dma.f
hw/afu_pkg.sv
hw/mmio_csr.sv
hw/host_rd_port.sv
hw/host_wr_port.sv
hw/dma_copy.sv
hw/afu_top.sv
verif/afu_props.sv
verif/afu_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = afu_tb
FILELIST = afu_dma.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "simulator exited with status $$status"; exit 1; fi
	@if grep -q "Result: FAILED" $(LOG); then echo "failures reported in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/afu_tb.sv
// afu_dma testbench
// host memory model, mmio driver and random copies checked against a memory model
`timescale 1ns/1ps

module afu_tb
	import afu_pkg::*;
();

	localparam int N_COPY    = 8;
	localparam int MEM_LINES = 1024;

	typedef struct packed {
		line_addr_t  addr;
		rd_tag_t     tag;
		logic [31:0] due;	// first cycle the response may go out
	} pend_rd_t;

	logic         clk;
	logic         arst_n;
	logic         mmio_req_valid;
	mmio_req_t    mmio_req;
	logic         mmio_rsp_valid;
	mmio_rsp_t    mmio_rsp;
	logic         host_rd_req_valid;
	host_rd_req_t host_rd_req;
	logic         host_rd_req_ready;
	logic         host_rd_rsp_valid;
	host_rd_rsp_t host_rd_rsp;
	logic         host_wr_req_valid;
	host_wr_req_t host_wr_req;
	logic         host_wr_req_ready;

	integer     seed = 64;
	line_data_t mem [MEM_LINES];	// host memory
	line_data_t model [MEM_LINES];	// expected host memory
	pend_rd_t   rd_q [$];	// reads waiting for their response
	int         cyc = 0;
	int         intr_cnt = 0;	// interrupt messages this copy
	int         line_cnt = 0;	// line writes this copy
	int         limit_cycles = 0;
	int         checks = 0;
	int         errors = 0;
	int         test_errs = 0;
	int         tests = 0;
	string      cur_test;
	line_addr_t src_l [N_COPY];
	line_addr_t dst_l [N_COPY];
	line_cnt_t  len_l [N_COPY];

	afu_top #(.RD_CREDITS(4), .BUF_DEPTH(8)) dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;	// 125 MHz
	end

	// *******************************************************************
	// checks and mmio driver
	// *******************************************************************
	task automatic expect_equal(input string what, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		assert (exp === act) else begin
			errors++;
			test_errs++;
			$display("ERR %s %s expected 0x%0h actual 0x%0h", cur_test, what, exp, act);
		end
	endtask

	task automatic expect_true(input logic cond, input string msg);
		checks++;
		assert (cond) else begin
			errors++;
			test_errs++;
			$display("error in %s: %s", cur_test, msg);
		end
	endtask

	task automatic finish_test();
		tests++;
		$display("test %-12s %s, %0d errors", cur_test, (test_errs == 0) ? "ok" : "fail", test_errs);
		test_errs = 0;
	endtask

	task automatic write_reg(input csr_addr_t idx, input csr_data_t val);
		mmio_req_valid = 1'b1;
		mmio_req       = '{addr: idx, wdata: val, write: 1'b1, tid: 8'h00};
		@(posedge clk);
		#1;
		mmio_req_valid = 1'b0;
		expect_true(!mmio_rsp_valid, "an mmio write produced a response");
	endtask

	task automatic read_reg(input csr_addr_t idx, output csr_data_t val);
		mmio_tid_t tid;
		tid            = mmio_tid_t'($random(seed));
		mmio_req_valid = 1'b1;
		mmio_req       = '{addr: idx, wdata: '0, write: 1'b0, tid: tid};
		@(posedge clk);
		#1;
		mmio_req_valid = 1'b0;
		expect_true(mmio_rsp_valid, "no mmio response one cycle after the read");
		expect_equal("tid", 64'(tid), 64'(mmio_rsp.tid));
		val = mmio_rsp.rdata;
	endtask

	// *******************************************************************
	// host memory, samples at negedge and drives 1 ns after posedge
	// *******************************************************************
	initial begin : host_model
		pend_rd_t p;
		forever begin
			@(negedge clk);
			if (host_rd_req_valid && host_rd_req_ready) begin
				expect_true(host_rd_req.addr < MEM_LINES, "host read outside the memory");
				p.addr = host_rd_req.addr;
				p.tag  = host_rd_req.tag;
				p.due  = cyc + 1 + ({$random(seed)} % 6);	// 1 to 6 cycles
				rd_q.push_back(p);
			end
			if (host_wr_req_valid && host_wr_req_ready) begin
				if (host_wr_req.intr) begin
					intr_cnt++;
				end else begin
					expect_true(intr_cnt == 0, "line write after the interrupt message");
					expect_true(host_wr_req.addr < MEM_LINES, "host write outside the memory");
					mem[host_wr_req.addr[9:0]] = host_wr_req.data;
					line_cnt++;
				end
			end
			@(posedge clk);
			cyc++;
			#1;
			host_rd_req_ready = ($random(seed) & 3) != 0;	// ready 3 of 4 cycles
			host_wr_req_ready = ($random(seed) & 3) != 0;
			if (rd_q.size() != 0 && rd_q[0].due <= cyc) begin
				p                 = rd_q.pop_front();	// in request order
				host_rd_rsp_valid = 1'b1;
				host_rd_rsp       = '{data: mem[p.addr[9:0]], tag: p.tag};
			end else begin
				host_rd_rsp_valid = 1'b0;
			end
		end
	end

	task automatic copy_block(input int k);
		csr_data_t st;
		cur_test = $sformatf("copy_%0d", k);
		write_reg(CSR_SRC, 64'(src_l[k]));
		write_reg(CSR_DST, 64'(dst_l[k]));
		write_reg(CSR_LEN, 64'(len_l[k]));
		for (int i = 0; i < len_l[k]; i++)
			model[dst_l[k] + i] = model[src_l[k] + i];	// regions never overlap
		intr_cnt = 0;
		line_cnt = 0;
		write_reg(CSR_CTRL, 64'h1);
		read_reg(CSR_STATUS, st);
		expect_equal("busy", 64'h1, 64'(st[0]));
		if (len_l[k] != 0)
			write_reg(CSR_CTRL, 64'h1);	// second start, still running
		while (intr_cnt == 0)
			@(posedge clk);
		repeat (20) @(posedge clk);	// room for a stray second interrupt
		#1;
		expect_equal("interrupts", 64'd1, 64'(intr_cnt));
		expect_equal("line writes", 64'(len_l[k]), 64'(line_cnt));
		read_reg(CSR_STATUS, st);
		expect_equal("status", 64'(k + 1) << 16, st);	// idle, count in 31:16
		for (int i = 0; i < MEM_LINES; i++)
			if (mem[i] !== model[i])
				expect_equal($sformatf("line 0x%0h", i), model[i], mem[i]);
		finish_test();
	endtask

	// *******************************************************************
	// test sequence
	// *******************************************************************
	initial begin : main
		int        total;
		csr_data_t v;
		csr_data_t wv;
		total             = 0;
		arst_n            = 1'b0;
		mmio_req_valid    = 1'b0;
		mmio_req          = '0;
		host_rd_req_ready = 1'b0;
		host_rd_rsp_valid = 1'b0;
		host_rd_rsp       = '0;
		host_wr_req_ready = 1'b0;
		for (int i = 0; i < MEM_LINES; i++) begin
			mem[i]   = {$random(seed), $random(seed)};
			model[i] = mem[i];
		end
		for (int k = 0; k < N_COPY; k++) begin
			len_l[k] = line_cnt_t'({$random(seed)} % 21);	// 0 to 20 lines
			src_l[k] = {$random(seed)} % 492;	// lower half
			dst_l[k] = 512 + {$random(seed)} % 492;	// upper half
			total += len_l[k];
		end
		limit_cycles = total * 40 + 2000;
		repeat (5) @(posedge clk);
		#1;
		arst_n = 1'b1;

		cur_test = "reset_state";
		expect_true(!host_rd_req_valid && !host_wr_req_valid, "host request valid after reset");
		for (int i = 0; i < 5; i++) begin
			read_reg(csr_addr_t'(i), v);
			expect_equal($sformatf("reg %0d", i), 64'h0, v);
		end
		finish_test();

		cur_test = "reg_readback";
		for (int i = 0; i < 3; i++) begin
			wv = {$random(seed), $random(seed)};
			write_reg(csr_addr_t'(i), wv);
			read_reg(csr_addr_t'(i), v);
			expect_equal($sformatf("reg %0d", i), (i == 2) ? 64'(wv[15:0]) : 64'(wv[31:0]), v);
		end
		finish_test();

		for (int k = 0; k < N_COPY; k++)
			copy_block(k);

		errors += dut_i.props_i.fail_cnt;	// bound channel properties
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		wait (limit_cycles != 0);
		repeat (limit_cycles) @(posedge clk);
		$display("timeout after %0d cycles, the copy engine stopped making progress", limit_cycles);
		$display("Result: FAILED");
		$finish;
	end

endmodule

// File: verif/afu_props.sv
// host channel properties for afu_dma
// handshake stability, read credit limit and no line writes while idle
`timescale 1ns/1ps

module afu_props
	import afu_pkg::*;
#(
	parameter int RD_CREDITS = 4
) (
	input logic         clk,
	input logic         arst_n,
	input logic         host_rd_req_valid,
	input host_rd_req_t host_rd_req,
	input logic         host_rd_req_ready,
	input logic         host_rd_rsp_valid,
	input logic         host_wr_req_valid,
	input host_wr_req_t host_wr_req,
	input logic         host_wr_req_ready,
	input logic         busy,
	input logic         done
);

	int   out_q;	// reads in flight
	logic intr_due;	// copy done, interrupt not yet sent
	int   fail_cnt = 0;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_q    <= 0;
			intr_due <= 1'b0;
		end else begin
			out_q <= out_q + int'(host_rd_req_valid && host_rd_req_ready) - int'(host_rd_rsp_valid);
			if (done) intr_due <= 1'b1;
			else if (host_wr_req_valid && host_wr_req_ready && host_wr_req.intr) intr_due <= 1'b0;
		end
	end

	a_rd_hold: assert property (@(posedge clk) disable iff (!arst_n)
		host_rd_req_valid && !host_rd_req_ready |=> host_rd_req_valid && $stable(host_rd_req))
		else begin
			fail_cnt <= fail_cnt + 1;
			$error("host read request dropped before transfer");
		end

	a_wr_hold: assert property (@(posedge clk) disable iff (!arst_n)
		host_wr_req_valid && !host_wr_req_ready |=> host_wr_req_valid && $stable(host_wr_req))
		else begin
			fail_cnt <= fail_cnt + 1;
			$error("host write request dropped before transfer");
		end

	a_credits: assert property (@(posedge clk) disable iff (!arst_n) out_q <= RD_CREDITS)
		else begin
			fail_cnt <= fail_cnt + 1;
			$error("more host reads in flight than credits");
		end

	// the last lines may still drain after done, up to the interrupt
	a_idle_wr: assert property (@(posedge clk) disable iff (!arst_n)
		host_wr_req_valid && host_wr_req_ready && !host_wr_req.intr |-> busy || intr_due)
		else begin
			fail_cnt <= fail_cnt + 1;
			$error("host line write while the engine is idle");
		end

endmodule

bind afu_top afu_props #(.RD_CREDITS(RD_CREDITS)) props_i (.*);

// File: hw/afu_top.sv
// afu_dma top level
// mmio bridge, host read and write ports and the copy engine
`timescale 1ns/1ps

module afu_top
	import afu_pkg::*;
#(
	parameter int RD_CREDITS = 4,
	parameter int BUF_DEPTH  = 8
) (
	input  logic         clk,
	input  logic         arst_n,
	input  logic         mmio_req_valid,
	input  mmio_req_t    mmio_req,
	output logic         mmio_rsp_valid,
	output mmio_rsp_t    mmio_rsp,
	output logic         host_rd_req_valid,
	output host_rd_req_t host_rd_req,
	input  logic         host_rd_req_ready,
	input  logic         host_rd_rsp_valid,
	input  host_rd_rsp_t host_rd_rsp,
	output logic         host_wr_req_valid,
	output host_wr_req_t host_wr_req,
	input  logic         host_wr_req_ready
);

	copy_cfg_t  cfg;
	logic       start;
	logic       busy;
	logic       done;	// also the interrupt request
	logic       rd_addr_valid;
	line_addr_t rd_addr;
	logic       rd_addr_ready;
	logic       rd_data_valid;
	line_data_t rd_data;
	logic       rd_data_ready;
	logic       wr_valid;
	line_addr_t wr_addr;
	line_data_t wr_data;
	logic       wr_ready;

	mmio_csr u_csr (.*);

	host_rd_port #(
		.RD_CREDITS (RD_CREDITS),
		.BUF_DEPTH  (BUF_DEPTH)
	) u_rd (.*);

	host_wr_port u_wr (
		.intr_req (done),
		.*
	);

	dma_copy u_dma (.*);

endmodule

// File: hw/dma_copy.sv
// copy engine
// walks src and dst line addresses, pairs buffered lines with write slots
`timescale 1ns/1ps

module dma_copy
	import afu_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  copy_cfg_t  cfg,
	input  logic       start,
	output logic       busy,
	output logic       done,
	output logic       rd_addr_valid,
	output line_addr_t rd_addr,
	input  logic       rd_addr_ready,
	input  logic       rd_data_valid,
	input  line_data_t rd_data,
	output logic       rd_data_ready,
	output logic       wr_valid,
	output line_addr_t wr_addr,
	output line_data_t wr_data,
	input  logic       wr_ready
);

	typedef enum logic {
		ST_IDLE,
		ST_RUN
	} state_e;

	state_e    state;
	copy_cfg_t cfg_q;	// job latched at start
	line_cnt_t rd_cnt;	// lines requested
	line_cnt_t wr_cnt;	// lines written
	logic      run;
	logic      rd_fire;
	logic      wr_fire;
	logic      last_wr;

	assign run  = (state == ST_RUN);
	assign busy = run;

	// *******************************************************************
	// read address side
	// *******************************************************************
	assign rd_addr_valid = run && (rd_cnt < cfg_q.len);
	assign rd_addr       = cfg_q.src + line_addr_t'(rd_cnt);
	assign rd_fire       = rd_addr_valid && rd_addr_ready;

	// *******************************************************************
	// write side, buffered line goes straight out with its dst slot
	// *******************************************************************
	assign wr_valid      = run && rd_data_valid;
	assign wr_addr       = cfg_q.dst + line_addr_t'(wr_cnt);
	assign wr_data       = rd_data;
	assign rd_data_ready = run && wr_ready;	// pop only on accept
	assign wr_fire       = wr_valid && wr_ready;

	assign last_wr = wr_fire && (wr_cnt == cfg_q.len - 16'd1);

	// zero length finishes in the first run cycle
	assign done = run && ((cfg_q.len == '0) || last_wr);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state  <= ST_IDLE;
			cfg_q  <= '0;
			rd_cnt <= '0;
			wr_cnt <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (start) begin
						state  <= ST_RUN;
						cfg_q  <= cfg;	// later csr writes don't disturb the job
						rd_cnt <= '0;
						wr_cnt <= '0;
					end
				end
				ST_RUN: begin
					if (rd_fire) rd_cnt <= rd_cnt + 1'b1;
					if (wr_fire) wr_cnt <= wr_cnt + 1'b1;
					if (done) state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// File: hw/host_wr_port.sv
// host write port
// output register with skid for line writes, then the completion interrupt
`timescale 1ns/1ps

module host_wr_port
	import afu_pkg::*;
(
	input  logic         clk,
	input  logic         arst_n,
	input  logic         wr_valid,
	input  line_addr_t   wr_addr,
	input  line_data_t   wr_data,
	output logic         wr_ready,
	input  logic         intr_req,
	output logic         host_wr_req_valid,
	output host_wr_req_t host_wr_req,
	input  logic         host_wr_req_ready
);

	host_wr_req_t skid_q;
	logic         skid_vld;
	logic         intr_pend;	// interrupt waiting behind writes
	logic         wr_fire;
	logic         out_free;
	logic         load_intr;

	// no new writes while the interrupt is pending, keeps copies apart
	assign wr_ready  = !skid_vld && !intr_pend;
	assign wr_fire   = wr_valid && wr_ready;
	assign out_free  = !host_wr_req_valid || host_wr_req_ready;
	assign load_intr = out_free && !skid_vld && intr_pend;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			host_wr_req_valid <= 1'b0;
			skid_vld          <= 1'b0;
			intr_pend         <= 1'b0;
		end else begin
			if (out_free) host_wr_req_valid <= skid_vld || intr_pend || wr_fire;
			if (out_free) skid_vld <= 1'b0;	// skid empties first
			else if (wr_fire) skid_vld <= 1'b1;	// output stalled
			if (intr_req) intr_pend <= 1'b1;
			else if (load_intr) intr_pend <= 1'b0;
		end
	end

	// payload, priority skid then interrupt then new write
	always_ff @(posedge clk) begin
		if (out_free) begin
			if (skid_vld) host_wr_req <= skid_q;
			else if (intr_pend) host_wr_req <= '{addr: '0, data: '0, intr: 1'b1};
			else if (wr_fire) host_wr_req <= '{addr: wr_addr, data: wr_data, intr: 1'b0};
		end else if (wr_fire) begin
			skid_q <= '{addr: wr_addr, data: wr_data, intr: 1'b0};
		end
	end

endmodule

// File: hw/host_rd_port.sv
// host read port
// issues tagged line reads under a credit limit and buffers the returns
`timescale 1ns/1ps

module host_rd_port
	import afu_pkg::*;
#(
	parameter int RD_CREDITS = 4,
	parameter int BUF_DEPTH  = 8
) (
	input  logic         clk,
	input  logic         arst_n,
	input  logic         rd_addr_valid,
	input  line_addr_t   rd_addr,
	output logic         rd_addr_ready,
	output logic         rd_data_valid,
	output line_data_t   rd_data,
	input  logic         rd_data_ready,
	output logic         host_rd_req_valid,
	output host_rd_req_t host_rd_req,
	input  logic         host_rd_req_ready,
	input  logic         host_rd_rsp_valid,
	input  host_rd_rsp_t host_rd_rsp
);

	localparam int PTR_W = $clog2(BUF_DEPTH);
	localparam int CNT_W = $clog2(BUF_DEPTH + 1);

	if (RD_CREDITS > BUF_DEPTH) begin : g_credit_chk
		$error("RD_CREDITS must not exceed BUF_DEPTH");
	end
	// slot index is taken from the tag, so depth must divide the tag space
	if (BUF_DEPTH < 2 || BUF_DEPTH > 16 || (BUF_DEPTH & (BUF_DEPTH - 1)) != 0) begin : g_depth_chk
		$error("BUF_DEPTH must be a power of two from 2 to 16");
	end

	line_data_t       buf_mem [BUF_DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] out_cnt;	// reads in flight
	logic [CNT_W-1:0] buf_cnt;	// lines waiting in buffer
	rd_tag_t          tag_q;	// rolling tag, next read
	logic             can_issue;
	logic             issue;
	logic             drain;

	// in flight reads keep their slot reserved
	assign can_issue = (out_cnt < CNT_W'(RD_CREDITS)) &&
	                   ((out_cnt + buf_cnt) < CNT_W'(BUF_DEPTH));

	assign host_rd_req_valid = rd_addr_valid && can_issue;
	assign host_rd_req       = '{addr: rd_addr, tag: tag_q};
	assign rd_addr_ready     = host_rd_req_ready && can_issue;
	assign issue             = host_rd_req_valid && host_rd_req_ready;

	assign rd_data_valid = (buf_cnt != '0);
	assign rd_data       = buf_mem[rd_ptr];
	assign drain         = rd_data_valid && rd_data_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			tag_q   <= '0;
			rd_ptr  <= '0;
			out_cnt <= '0;
			buf_cnt <= '0;
		end else begin
			if (issue) tag_q <= tag_q + 1'b1;
			if (drain) rd_ptr <= rd_ptr + 1'b1;	// wraps with the depth
			out_cnt <= out_cnt + CNT_W'(issue) - CNT_W'(host_rd_rsp_valid);
			buf_cnt <= buf_cnt + CNT_W'(host_rd_rsp_valid) - CNT_W'(drain);
		end
	end

	// returns come in order, tag picks the reserved slot
	always_ff @(posedge clk) begin
		if (host_rd_rsp_valid) buf_mem[host_rd_rsp.tag[PTR_W-1:0]] <= host_rd_rsp.data;
	end

endmodule

// File: hw/mmio_csr.sv
// mmio register bridge
// decodes host register accesses, holds the copy job and answers reads
`timescale 1ns/1ps

module mmio_csr
	import afu_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  logic      mmio_req_valid,
	input  mmio_req_t mmio_req,
	output logic      mmio_rsp_valid,
	output mmio_rsp_t mmio_rsp,
	output copy_cfg_t cfg,
	output logic      start,
	input  logic      busy,
	input  logic      done
);

	csr_addr_t idx;
	logic      wr_en;
	logic      rd_en;
	line_cnt_t done_cnt;	// completed copies
	csr_data_t rdata_nxt;

	assign idx   = mmio_req.addr;
	assign wr_en = mmio_req_valid && mmio_req.write;
	assign rd_en = mmio_req_valid && !mmio_req.write;

	// start only from idle, engine ignores it otherwise anyway
	assign start = wr_en && (idx == CSR_CTRL) && mmio_req.wdata[0] && !busy;

	// *******************************************************************
	// copy registers
	// *******************************************************************
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cfg <= '0;
		end else if (wr_en) begin
			case (idx)
				CSR_SRC: cfg.src <= mmio_req.wdata[31:0];	// low word only
				CSR_DST: cfg.dst <= mmio_req.wdata[31:0];
				CSR_LEN: cfg.len <= mmio_req.wdata[15:0];
				default: ;	// ctrl handled by start, rest read only
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			done_cnt <= '0;
		end else if (done) begin
			done_cnt <= done_cnt + 1'b1;	// wraps at 64k
		end
	end

	// *******************************************************************
	// read path, one cycle latency
	// *******************************************************************
	always_comb begin
		case (idx)
			CSR_SRC:    rdata_nxt = {32'b0, cfg.src};
			CSR_DST:    rdata_nxt = {32'b0, cfg.dst};
			CSR_LEN:    rdata_nxt = {48'b0, cfg.len};
			CSR_STATUS: rdata_nxt = {32'b0, done_cnt, 15'b0, busy};
			default:    rdata_nxt = '0;	// ctrl reads as zero
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mmio_rsp_valid <= 1'b0;
		end else begin
			mmio_rsp_valid <= rd_en;	// writes get no response
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			mmio_rsp.rdata <= rdata_nxt;
			mmio_rsp.tid   <= mmio_req.tid;
		end
	end

endmodule

// File: hw/afu_pkg.sv
// afu_dma shared definitions
// line, address and register types, channel structs and the register map
package afu_pkg;

	// *******************************************************************
	// plain vector types
	// *******************************************************************
	typedef logic [31:0] line_addr_t;	// host line address
	typedef logic [63:0] line_data_t;	// one data line
	typedef logic [3:0]  rd_tag_t;	// read request tag
	typedef logic [3:0]  csr_addr_t;	// register index
	typedef logic [7:0]  mmio_tid_t;	// mmio transaction id
	typedef logic [15:0] line_cnt_t;	// line count
	typedef logic [63:0] csr_data_t;	// mmio data word

	// register map
	localparam csr_addr_t CSR_SRC    = 4'd0;	// source line address
	localparam csr_addr_t CSR_DST    = 4'd1;	// destination line address
	localparam csr_addr_t CSR_LEN    = 4'd2;	// number of lines
	localparam csr_addr_t CSR_CTRL   = 4'd3;	// bit 0 starts a copy
	localparam csr_addr_t CSR_STATUS = 4'd4;	// bit 0 busy, 31:16 done count

	// *******************************************************************
	// channel payloads
	// *******************************************************************
	typedef struct packed {
		csr_addr_t addr;
		csr_data_t wdata;
		logic      write;	// 0 means read
		mmio_tid_t tid;
	} mmio_req_t;

	typedef struct packed {
		csr_data_t rdata;
		mmio_tid_t tid;	// echoed from the request
	} mmio_rsp_t;

	typedef struct packed {
		line_addr_t addr;
		rd_tag_t    tag;
	} host_rd_req_t;

	typedef struct packed {
		line_data_t data;
		rd_tag_t    tag;
	} host_rd_rsp_t;

	typedef struct packed {
		line_addr_t addr;	// don't care when intr set
		line_data_t data;	// don't care when intr set
		logic       intr;	// interrupt message
	} host_wr_req_t;

	// copy job as programmed over mmio
	typedef struct packed {
		line_addr_t src;
		line_addr_t dst;
		line_cnt_t  len;
	} copy_cfg_t;

endpackage
